//--- rtl/axi_burst_pkg.sv
// AXI4 burst definitions.
// Burst kinds, response codes and field widths for the channel controllers.

package axi_burst_pkg;

	// Widths of the AXI4 fields the slave decodes.
	localparam int LEN_W = 8;
	localparam int BURST_W = 2;
	localparam int RESP_W = 2;

	// AxBURST encodings.
	typedef enum logic [BURST_W-1:0] {
		BURST_FIXED = 2'b00,
		BURST_INCR = 2'b01,
		BURST_WRAP = 2'b10
	} burst_e;

	// xRESP encodings.
	// EXOKAY and DECERR never leave this slave.
	typedef enum logic [RESP_W-1:0] {
		RESP_OKAY = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

endpackage

//--- rtl/sram_pkg.sv
// SRAM geometry defaults and preload rule.
// Shared by the SRAM model and the checking side.

package sram_pkg;

	// Default word width in bits.
	localparam int DATA_W_DEF = 64;

	// Default word address width, 16K words.
	localparam int MEM_AW_DEF = 14;

	// Preload value of word idx.
	// The index is zero extended to the word width.
	function automatic logic [DATA_W_DEF-1:0] sram_init_word(input int unsigned idx);
		logic [DATA_W_DEF-1:0] word;
		word = DATA_W_DEF'(idx);
		return word;
	endfunction

endpackage

//--- rtl/axi_burst_addr.sv
// Burst address and beat counter.
// Loads on the address handshake and steps once per advanced beat.
`timescale 1ns/1ns

module axi_burst_addr
	import axi_burst_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 64
) (
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              load,
	input  logic [ADDR_W-1:0] start_addr,
	input  logic [LEN_W-1:0]  len,
	input  burst_e            burst,
	input  logic              advance,
	output logic [ADDR_W-1:0] addr,
	output logic              last,
	output logic              wrap_err
);

	// One beat moves the address by the full bus width.
	localparam int ADDR_LSB = $clog2(DATA_W / 8);

	logic [LEN_W-1:0] len_q;
	logic [LEN_W-1:0] cnt_q;
	burst_e burst_q;

	// The address steps one bus word per beat for INCR only.
	always_ff @(posedge CLK) begin
		if (load) begin
			addr <= start_addr;
			len_q <= len;
		end else if (advance && burst_q == BURST_INCR) begin
			addr <= addr + (ADDR_W'(1) << ADDR_LSB);
		end
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			cnt_q <= '0;
			burst_q <= BURST_FIXED;
		end else if (load) begin
			cnt_q <= '0;
			burst_q <= burst;
		end else if (advance) begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign last = (cnt_q == len_q);
	assign wrap_err = (burst_q == BURST_WRAP);

endmodule

//--- rtl/axi_rw_arbiter.sv
// Read/write arbiter.
// Grants the slave to one transaction at a time, alternating on contest.
`timescale 1ns/1ns

module axi_rw_arbiter (
	input  logic CLK,
	input  logic rst_n,
	input  logic awvalid,
	input  logic arvalid,
	input  logic wr_done,
	input  logic rd_done,
	output logic wr_grant,
	output logic rd_grant
);

	// Set when the read side wins the next contest.
	logic prio_rd;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			wr_grant <= 1'b0;
			rd_grant <= 1'b0;
			prio_rd <= 1'b0;
		end else if (wr_grant) begin
			if (wr_done)
				wr_grant <= 1'b0;
		end else if (rd_grant) begin
			if (rd_done)
				rd_grant <= 1'b0;
		end else if (awvalid && (!arvalid || !prio_rd)) begin
			wr_grant <= 1'b1;
			// Priority only flips when the other side was also waiting.
			if (arvalid)
				prio_rd <= 1'b1;
		end else if (arvalid) begin
			rd_grant <= 1'b1;
			if (awvalid)
				prio_rd <= 1'b0;
		end
	end

	// Both channels share the SRAM, so only one may own it.
	a_grant_onehot: assert property (@(posedge CLK) disable iff (!rst_n)
		!(wr_grant && rd_grant))
		else $error("write and read granted together");

endmodule

//--- rtl/axi_wr_channel.sv
// AXI4 write channel controller.
// Runs AW, W and B phases and turns accepted beats into strobed SRAM writes.
`timescale 1ns/1ns

module axi_wr_channel
	import axi_burst_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 64,
	parameter int MEM_AW = 14
) (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic                wr_grant,
	input  logic [ADDR_W-1:0]   awaddr,
	input  logic [LEN_W-1:0]    awlen,
	input  logic [BURST_W-1:0]  awburst,
	input  logic                awvalid,
	input  logic [DATA_W-1:0]   wdata,
	input  logic [DATA_W/8-1:0] wstrb,
	input  logic                wlast,
	input  logic                wvalid,
	input  logic                bready,
	output logic                awready,
	output logic                wready,
	output logic [RESP_W-1:0]   bresp,
	output logic                bvalid,
	output logic                wr_done,
	output logic                mem_we,
	output logic [MEM_AW-1:0]   mem_waddr,
	output logic [DATA_W-1:0]   mem_wdata,
	output logic [DATA_W/8-1:0] mem_wstrb
);

	localparam int ADDR_LSB = $clog2(DATA_W / 8);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_ADDR,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	wr_state_e state;
	logic aw_hs;
	logic w_hs;
	logic [ADDR_W-1:0] beat_addr;
	logic wrap_err;

	assign awready = (state == WR_ADDR);
	assign wready = (state == WR_DATA);
	assign bvalid = (state == WR_RESP);
	assign aw_hs = awready && awvalid;
	assign w_hs = wready && wvalid;
	assign wr_done = bvalid && bready;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= WR_IDLE;
		end else begin
			case (state)
				WR_IDLE: if (wr_grant) state <= WR_ADDR;
				WR_ADDR: if (aw_hs) state <= WR_DATA;
				// The burst ends on WLAST, not on the beat count.
				WR_DATA: if (w_hs && wlast) state <= WR_RESP;
				WR_RESP: if (wr_done) state <= WR_IDLE;
				default: state <= WR_IDLE;
			endcase
		end
	end

	axi_burst_addr #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W)
	) i_aw_addr (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.load      (aw_hs),
		.start_addr(awaddr),
		.len       (awlen),
		.burst     (burst_e'(awburst)),
		.advance   (w_hs),
		.addr      (beat_addr),
		.last      (),
		.wrap_err  (wrap_err)
	);

	// WRAP bursts are drained without touching memory.
	assign mem_we = w_hs && !wrap_err;
	assign mem_waddr = beat_addr[ADDR_LSB +: MEM_AW];
	assign mem_wdata = wdata;
	assign mem_wstrb = wstrb;
	assign bresp = wrap_err ? RESP_SLVERR : RESP_OKAY;

	a_wready_granted: assert property (@(posedge CLK) disable iff (!rst_n)
		wready |-> wr_grant)
		else $error("WREADY high without a write grant");

endmodule

//--- rtl/axi_rd_channel.sv
// AXI4 read channel controller.
// Runs AR and R phases, prefetching the next word on every R handshake.
`timescale 1ns/1ns

module axi_rd_channel
	import axi_burst_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 64,
	parameter int MEM_AW = 14
) (
	input  logic               CLK,
	input  logic               rst_n,
	input  logic               rd_grant,
	input  logic [ADDR_W-1:0]  araddr,
	input  logic [LEN_W-1:0]   arlen,
	input  logic [BURST_W-1:0] arburst,
	input  logic               arvalid,
	input  logic               rready,
	input  logic [DATA_W-1:0]  mem_rdata,
	output logic               arready,
	output logic [DATA_W-1:0]  rdata,
	output logic [RESP_W-1:0]  rresp,
	output logic               rlast,
	output logic               rvalid,
	output logic               rd_done,
	output logic               mem_re,
	output logic [MEM_AW-1:0]  mem_raddr
);

	localparam int ADDR_LSB = $clog2(DATA_W / 8);

	typedef enum logic [1:0] {
		RD_IDLE,
		RD_ADDR,
		RD_FETCH,
		RD_DATA
	} rd_state_e;

	rd_state_e state;
	logic ar_hs;
	logic r_hs;
	logic issue;
	logic [ADDR_W-1:0] beat_addr;
	logic beat_last;
	logic wrap_err;

	assign arready = (state == RD_ADDR);
	assign rvalid = (state == RD_DATA);
	assign ar_hs = arready && arvalid;
	assign r_hs = rvalid && rready;
	assign rd_done = r_hs && rlast;

	// A read goes out for the first beat and again on each non-final handshake.
	assign issue = (state == RD_FETCH) || (r_hs && !rlast);

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state <= RD_IDLE;
		end else begin
			case (state)
				RD_IDLE: if (rd_grant) state <= RD_ADDR;
				RD_ADDR: if (ar_hs) state <= RD_FETCH;
				RD_FETCH: state <= RD_DATA;
				RD_DATA: if (rd_done) state <= RD_IDLE;
				default: state <= RD_IDLE;
			endcase
		end
	end

	// RLAST travels with the word it was issued for.
	always_ff @(posedge CLK) begin
		if (!rst_n)
			rlast <= 1'b0;
		else if (issue)
			rlast <= beat_last;
		else if (rd_done)
			rlast <= 1'b0;
	end

	axi_burst_addr #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W)
	) i_ar_addr (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.load      (ar_hs),
		.start_addr(araddr),
		.len       (arlen),
		.burst     (burst_e'(arburst)),
		.advance   (issue),
		.addr      (beat_addr),
		.last      (beat_last),
		.wrap_err  (wrap_err)
	);

	// The counter still runs for WRAP so RLAST lands on the right beat.
	assign mem_re = issue && !wrap_err;
	assign mem_raddr = beat_addr[ADDR_LSB +: MEM_AW];
	assign rdata = wrap_err ? '0 : mem_rdata;
	assign rresp = wrap_err ? RESP_SLVERR : RESP_OKAY;

	a_r_stable: assert property (@(posedge CLK) disable iff (!rst_n)
		rvalid && !rready |=> $stable(rdata) && $stable(rlast))
		else $error("R payload changed while stalled");

endmodule

//--- rtl/sram_2p.sv
// Two-port SRAM with byte-lane writes and a registered read port.
// Every word starts out holding its preload value.
`timescale 1ns/1ns

module sram_2p
	import sram_pkg::*;
#(
	parameter int DATA_W = DATA_W_DEF,
	parameter int MEM_AW = MEM_AW_DEF
) (
	input  logic                CLK,
	input  logic                we,
	input  logic [MEM_AW-1:0]   waddr,
	input  logic [DATA_W-1:0]   wdata,
	input  logic [DATA_W/8-1:0] wstrb,
	input  logic                re,
	input  logic [MEM_AW-1:0]   raddr,
	output logic [DATA_W-1:0]   rdata
);

	localparam int DEPTH = 2 ** MEM_AW;
	localparam int NBYTES = DATA_W / 8;

	logic [DATA_W-1:0] mem [DEPTH];

	initial begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] = DATA_W'(sram_init_word(i));
	end

	// Only the strobed byte lanes are updated.
	always @(posedge CLK) begin
		if (we) begin
			for (int b = 0; b < NBYTES; b++) begin
				if (wstrb[b])
					mem[waddr][b*8 +: 8] <= wdata[b*8 +: 8];
			end
		end
	end

	// Output holds its last word while re is low.
	always_ff @(posedge CLK) begin
		if (re)
			rdata <= mem[raddr];
	end

endmodule

//--- rtl/axi_sram_slave.sv
// AXI4 burst slave in front of a 64-bit on-chip SRAM.
// One transaction runs at a time, write and read take turns on contest.
`timescale 1ns/1ns

module axi_sram_slave
	import axi_burst_pkg::*;
	import sram_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 64,
	parameter int MEM_AW = MEM_AW_DEF
) (
	input  logic                CLK,
	input  logic                rst_n,
	input  logic [ADDR_W-1:0]   awaddr,
	input  logic [LEN_W-1:0]    awlen,
	input  logic [BURST_W-1:0]  awburst,
	input  logic                awvalid,
	output logic                awready,
	input  logic [DATA_W-1:0]   wdata,
	input  logic [DATA_W/8-1:0] wstrb,
	input  logic                wlast,
	input  logic                wvalid,
	output logic                wready,
	output logic [RESP_W-1:0]   bresp,
	output logic                bvalid,
	input  logic                bready,
	input  logic [ADDR_W-1:0]   araddr,
	input  logic [LEN_W-1:0]    arlen,
	input  logic [BURST_W-1:0]  arburst,
	input  logic                arvalid,
	output logic                arready,
	output logic [DATA_W-1:0]   rdata,
	output logic [RESP_W-1:0]   rresp,
	output logic                rlast,
	output logic                rvalid,
	input  logic                rready
);

	logic wr_grant;
	logic rd_grant;
	logic wr_done;
	logic rd_done;
	logic mem_we;
	logic [MEM_AW-1:0] mem_waddr;
	logic [DATA_W-1:0] mem_wdata;
	logic [DATA_W/8-1:0] mem_wstrb;
	logic mem_re;
	logic [MEM_AW-1:0] mem_raddr;
	logic [DATA_W-1:0] mem_rdata;

	axi_rw_arbiter i_arbiter (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.awvalid (awvalid),
		.arvalid (arvalid),
		.wr_done (wr_done),
		.rd_done (rd_done),
		.wr_grant(wr_grant),
		.rd_grant(rd_grant)
	);

	axi_wr_channel #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W),
		.MEM_AW(MEM_AW)
	) i_wr_channel (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.wr_grant (wr_grant),
		.awaddr   (awaddr),
		.awlen    (awlen),
		.awburst  (awburst),
		.awvalid  (awvalid),
		.wdata    (wdata),
		.wstrb    (wstrb),
		.wlast    (wlast),
		.wvalid   (wvalid),
		.bready   (bready),
		.awready  (awready),
		.wready   (wready),
		.bresp    (bresp),
		.bvalid   (bvalid),
		.wr_done  (wr_done),
		.mem_we   (mem_we),
		.mem_waddr(mem_waddr),
		.mem_wdata(mem_wdata),
		.mem_wstrb(mem_wstrb)
	);

	axi_rd_channel #(
		.ADDR_W(ADDR_W),
		.DATA_W(DATA_W),
		.MEM_AW(MEM_AW)
	) i_rd_channel (
		.CLK      (CLK),
		.rst_n    (rst_n),
		.rd_grant (rd_grant),
		.araddr   (araddr),
		.arlen    (arlen),
		.arburst  (arburst),
		.arvalid  (arvalid),
		.rready   (rready),
		.mem_rdata(mem_rdata),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rlast    (rlast),
		.rvalid   (rvalid),
		.rd_done  (rd_done),
		.mem_re   (mem_re),
		.mem_raddr(mem_raddr)
	);

	sram_2p #(
		.DATA_W(DATA_W),
		.MEM_AW(MEM_AW)
	) i_sram (
		.CLK  (CLK),
		.we   (mem_we),
		.waddr(mem_waddr),
		.wdata(mem_wdata),
		.wstrb(mem_wstrb),
		.re   (mem_re),
		.raddr(mem_raddr),
		.rdata(mem_rdata)
	);

endmodule

//--- dv/tb_clk_gen.sv
// Testbench clock source.
// Free-running CLK with a 4 ns period.
`timescale 1ns/1ns

module tb_clk_gen #(
	parameter int HALF_NS = 2
) (
	output logic CLK
);

	initial begin
		CLK = 1'b0;
		forever #HALF_NS CLK = ~CLK;
	end

endmodule

//--- dv/tb_axi_sram_slave.sv
// Testbench for the AXI4 burst SRAM slave.
// Random bursts against a shadow memory, with protocol assertions.
`timescale 1ns/1ns

module tb_axi_sram_slave
	import axi_burst_pkg::*;
	import sram_pkg::*;
();

	localparam int DEPTH = 2 ** MEM_AW_DEF;
	localparam int BYTE_SHIFT = 3;
	localparam int TIMEOUT_MARGIN = 200;

	logic CLK;
	logic rst_n;
	logic [31:0] awaddr;
	logic [7:0] awlen;
	logic [1:0] awburst;
	logic awvalid;
	logic awready;
	logic [63:0] wdata;
	logic [7:0] wstrb;
	logic wlast;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [31:0] araddr;
	logic [7:0] arlen;
	logic [1:0] arburst;
	logic arvalid;
	logic arready;
	logic [63:0] rdata;
	logic [1:0] rresp;
	logic rlast;
	logic rvalid;
	logic rready;

	logic [63:0] shadow [DEPTH];
	int seed = 32'hfa4e_0ed2;
	int value_errs = 0;
	int proto_errs = 0;
	int issued_beats = 0;
	int cycles = 0;

	tb_clk_gen i_clk_gen (.CLK(CLK));

	axi_sram_slave #(.ADDR_W(32), .DATA_W(64), .MEM_AW(MEM_AW_DEF)) i_dut (.*);

	task automatic flag_mismatch(input string msg);
		value_errs++;
		$display("[FAIL] %0t ns: %s", $time, msg);
	endtask

	task automatic flag_protocol(input string msg);
		proto_errs++;
		$display("[FAIL] %0t ns: %s", $time, msg);
	endtask

	a_grants_exclusive: assert property (@(posedge CLK) disable iff (!rst_n)
		!(i_dut.wr_grant && i_dut.rd_grant))
		else flag_protocol("write and read grants high together");
	a_w_granted: assert property (@(posedge CLK) disable iff (!rst_n)
		wready |-> i_dut.wr_grant)
		else flag_protocol("WREADY high without a write grant");
	a_r_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast) && $stable(rresp))
		else flag_protocol("R beat dropped or changed while stalled");
	a_b_hold: assert property (@(posedge CLK) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else flag_protocol("B response dropped or changed while stalled");

	// Inputs change 1 ns after the rising edge.
	task automatic step();
		@(posedge CLK);
		#1;
	endtask

	function automatic bit coin_flip();
		return ($random(seed) & 1) == 1;
	endfunction

	function automatic int unsigned beat_index(input logic [31:0] addr, input burst_e kind,
			input int beat);
		if (kind == BURST_INCR)
			return ((addr >> BYTE_SHIFT) + beat) & (DEPTH - 1);
		return (addr >> BYTE_SHIFT) & (DEPTH - 1);
	endfunction

	task automatic check_idle(input string when);
		assert (!awready && !wready && !bvalid && !arready && !rvalid && !rlast)
			else flag_mismatch({"ready or valid output high ", when});
		assert (!i_dut.wr_grant && !i_dut.rd_grant)
			else flag_mismatch({"grant high ", when});
	endtask

	task automatic write_burst(input logic [31:0] addr, input int len, input burst_e kind);
		int unsigned idx;
		resp_e exp_resp;
		bit got;
		exp_resp = (kind == BURST_WRAP) ? RESP_SLVERR : RESP_OKAY;
		issued_beats += len + 1;
		awaddr = addr;
		awlen = 8'(len);
		awburst = kind;
		awvalid = 1'b1;
		do @(negedge CLK); while (!awready);
		step();
		awvalid = 1'b0;
		for (int i = 0; i <= len; i++) begin
			if (coin_flip()) begin
				wvalid = 1'b0;
				step();
			end
			wdata = {$random(seed), $random(seed)};
			wstrb = 8'($random(seed));
			wlast = (i == len);
			wvalid = 1'b1;
			do @(negedge CLK); while (!wready);
			// Merge strobed bytes into the expected word.
			if (kind != BURST_WRAP) begin
				idx = beat_index(addr, kind, i);
				for (int b = 0; b < 8; b++)
					if (wstrb[b])
						shadow[idx][b*8 +: 8] = wdata[b*8 +: 8];
			end
			step();
		end
		wvalid = 1'b0;
		wlast = 1'b0;
		got = 1'b0;
		while (!got) begin
			bready = coin_flip();
			@(negedge CLK);
			got = bvalid && bready;
			if (got)
				assert (bresp == exp_resp)
					else flag_mismatch($sformatf("BRESP %0d, expected %0d", bresp, exp_resp));
			step();
		end
		bready = 1'b0;
	endtask

	task automatic read_burst(input logic [31:0] addr, input int len, input burst_e kind);
		logic [63:0] exp_data;
		resp_e exp_resp;
		int beat;
		exp_resp = (kind == BURST_WRAP) ? RESP_SLVERR : RESP_OKAY;
		issued_beats += len + 1;
		araddr = addr;
		arlen = 8'(len);
		arburst = kind;
		arvalid = 1'b1;
		do @(negedge CLK); while (!arready);
		step();
		arvalid = 1'b0;
		beat = 0;
		while (beat <= len) begin
			rready = coin_flip();
			@(negedge CLK);
			if (rvalid && rready) begin
				exp_data = (kind == BURST_WRAP) ? '0 : shadow[beat_index(addr, kind, beat)];
				assert (rdata == exp_data)
					else flag_mismatch($sformatf("beat %0d RDATA %h, expected %h",
						beat, rdata, exp_data));
				assert (rresp == exp_resp)
					else flag_mismatch($sformatf("RRESP %0d, expected %0d", rresp, exp_resp));
				assert (rlast == (beat == len))
					else flag_mismatch($sformatf("RLAST %b on beat %0d of %0d",
						rlast, beat, len));
				beat++;
			end
			step();
		end
		rready = 1'b0;
		@(negedge CLK);
		assert (!rvalid) else flag_mismatch("extra R beat after RLAST");
		step();
	endtask

	function automatic logic [31:0] rand_addr();
		return $random(seed) & 32'h000f_fff8;
	endfunction

	task automatic end_run(input bit hung);
		$display("Error counts: value %0d, protocol %0d", value_errs, proto_errs);
		if (!hung && value_errs == 0 && proto_errs == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	// Limit grows with every burst that is issued.
	initial begin
		while (cycles < 64 * issued_beats + TIMEOUT_MARGIN) begin
			@(posedge CLK);
			cycles++;
		end
		$display("Timeout: the DUT stopped responding after %0d cycles", cycles);
		end_run(1'b1);
	end

	initial begin
		logic [31:0] addr;
		int len;
		{awaddr, awlen, awburst, awvalid, wdata, wstrb, wlast, wvalid, bready} = '0;
		{araddr, arlen, arburst, arvalid, rready} = '0;
		rst_n = 1'b0;
		for (int i = 0; i < DEPTH; i++)
			shadow[i] = sram_init_word(i);
		repeat (3) begin
			step();
			check_idle("during reset");
		end
		rst_n = 1'b1;
		step();
		check_idle("after reset");
		read_burst(rand_addr(), 3, BURST_INCR);
		for (int n = 0; n < 6; n++) begin
			addr = rand_addr();
			len = $random(seed) & 15;
			write_burst(addr, len, BURST_INCR);
			read_burst(addr, len, BURST_INCR);
		end
		addr = rand_addr();
		write_burst(addr, 255, BURST_INCR);
		read_burst(addr, 255, BURST_INCR);
		addr = rand_addr();
		write_burst(addr, 5, BURST_FIXED);
		read_burst(addr, 5, BURST_FIXED);
		// Two contests, so each side wins one of them.
		repeat (2) begin
			addr = rand_addr();
			fork
				write_burst(addr, 7, BURST_INCR);
				read_burst(addr + 32'h0000_8000, 7, BURST_INCR);
			join
			read_burst(addr, 7, BURST_INCR);
		end
		addr = rand_addr();
		write_burst(addr, 4, BURST_WRAP);
		read_burst(addr, 4, BURST_INCR);
		read_burst(addr, 3, BURST_WRAP);
		end_run(1'b0);
	end

endmodule

//--- axi_sram_slave.f
rtl/axi_burst_pkg.sv
rtl/sram_pkg.sv
rtl/axi_burst_addr.sv
rtl/axi_rw_arbiter.sv
rtl/axi_wr_channel.sv
rtl/axi_rd_channel.sv
rtl/sram_2p.sv
rtl/axi_sram_slave.sv
dv/tb_clk_gen.sv
dv/tb_axi_sram_slave.sv
